// ==== Bender.yml ====
package:
  name: mem_if_multi_bank

sources:
  - hdl/mem_if_cfg_pkg.sv
  - hdl/lp_bus_pkg.sv
  - hdl/lp_write_ctrl.sv
  - hdl/lp_read_ctrl.sv
  - hdl/bank_xbar.sv
  - hdl/read_return.sv
  - hdl/mem_if_multi_bank.sv
  - target: test
    files:
      - testbench/mem_if_checker.sv
      - testbench/tb_mem_if_multi_bank.sv

// ==== hdl/bank_xbar.sv ====
`timescale 1ns/1ps

module bank_xbar #(
   parameter int NB_BANKS = 4
) (
   input  logic                                     aclk_i,
   input  logic                                     rst_n_i,

   input  lp_bus_pkg::port_req_t                    hp_req_i,
   input  logic                                     hp_valid_i,

   input  lp_bus_pkg::port_req_t                    lpw_req_i,
   input  lp_bus_pkg::port_req_t                    lpr_req_i,
   input  logic                                     lpw_valid_i,
   input  logic                                     lpr_valid_i,
   output logic                                     lpw_grant_o,
   output logic                                     lpr_grant_o,

   output logic                                     hp_rd_o,
   output logic                                     lpr_rd_o,
   output logic [$clog2(NB_BANKS)-1:0]              hp_bank_o,
   output logic [$clog2(NB_BANKS)-1:0]              lpr_bank_o,

   output logic [NB_BANKS-1:0]                      bank_cen_o,
   output mem_if_cfg_pkg::bank_req_t [NB_BANKS-1:0] bank_req_o
);

   localparam int BANK_BITS = $clog2(NB_BANKS);
   localparam int ROW_LSB   = mem_if_cfg_pkg::OFFSET_BITS + BANK_BITS;

   logic [BANK_BITS-1:0] hp_bank, lpw_bank, lpr_bank;
   logic [NB_BANKS-1:0]  hp_gnt, lpw_gnt, lpr_gnt;

   // Set means the read controller wins the next tie
   logic rr_flag_q;

   // Map a request onto the SRAM pins of its bank
   function automatic mem_if_cfg_pkg::bank_req_t to_bank(
      input lp_bus_pkg::port_req_t req,
      input logic                  active
   );
      mem_if_cfg_pkg::bank_req_t b;
      b.wen   = ~(req.we & active);
      b.row   = req.addr[ROW_LSB +: mem_if_cfg_pkg::ROW_WIDTH];
      b.wdata = req.data;
      b.be    = req.be;
      return b;
   endfunction

   // --------------------
   // Address decode
   // --------------------

   // Word interleaved, bits above the row are dropped
   assign hp_bank  = hp_req_i.addr[mem_if_cfg_pkg::OFFSET_BITS +: BANK_BITS];
   assign lpw_bank = lpw_req_i.addr[mem_if_cfg_pkg::OFFSET_BITS +: BANK_BITS];
   assign lpr_bank = lpr_req_i.addr[mem_if_cfg_pkg::OFFSET_BITS +: BANK_BITS];

   // --------------------
   // Per-bank arbitration
   // --------------------

   for (genvar b = 0; b < NB_BANKS; b++) begin : g_bank
      logic lpw_hit;
      logic lpr_hit;

      assign lpw_hit = lpw_valid_i && (lpw_bank == BANK_BITS'(b));
      assign lpr_hit = lpr_valid_i && (lpr_bank == BANK_BITS'(b));

      // High priority is never held off
      assign hp_gnt[b]  = hp_valid_i && (hp_bank == BANK_BITS'(b));
      assign lpw_gnt[b] = lpw_hit && !hp_gnt[b] && (!lpr_hit || !rr_flag_q);
      assign lpr_gnt[b] = lpr_hit && !hp_gnt[b] && (!lpw_hit || rr_flag_q);

      assign bank_cen_o[b] = ~(hp_gnt[b] | lpw_gnt[b] | lpr_gnt[b]);

      assign bank_req_o[b] = hp_gnt[b]  ? to_bank(hp_req_i, 1'b1)  :
                             lpr_gnt[b] ? to_bank(lpr_req_i, 1'b1) :
                                          to_bank(lpw_req_i, lpw_gnt[b]);

      a_one_grant: assert property (
         @(posedge aclk_i) disable iff (!rst_n_i)
         $onehot0({hp_gnt[b], lpw_gnt[b], lpr_gnt[b]})
      );
   end

   // Flip after any low-priority grant, on whichever bank
   always_ff @(posedge aclk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rr_flag_q <= 1'b0;
      end else if (|lpw_gnt || |lpr_gnt) begin
         rr_flag_q <= ~rr_flag_q;
      end
   end

   // --------------------
   // Grants and read tags
   // --------------------

   assign lpw_grant_o = |lpw_gnt;
   assign lpr_grant_o = |lpr_gnt;

   assign hp_rd_o    = hp_valid_i && !hp_req_i.we;
   assign lpr_rd_o   = lpr_grant_o;
   assign hp_bank_o  = hp_bank;
   assign lpr_bank_o = lpr_bank;

endmodule

// ==== hdl/lp_bus_pkg.sv ====
package lp_bus_pkg;

   // --------------------
   // Low-priority bus
   // --------------------

   // Write request channel, address and data merged in one beat
   typedef struct packed {
      mem_if_cfg_pkg::addr_t addr;
      mem_if_cfg_pkg::data_t data;
      mem_if_cfg_pkg::be_t   be;
   } lp_wreq_t;

   // Read request channel
   typedef struct packed {
      mem_if_cfg_pkg::addr_t addr;
   } lp_rreq_t;

   // --------------------
   // Crossbar side
   // --------------------

   // Common request format of both controllers and the high-priority port
   // we is active high here, the SRAM polarity is applied in the crossbar
   typedef struct packed {
      logic                  we;
      mem_if_cfg_pkg::addr_t addr;
      mem_if_cfg_pkg::data_t data;
      mem_if_cfg_pkg::be_t   be;
   } port_req_t;

   // Reads carry no payload besides the address
   parameter port_req_t PORT_REQ_IDLE = '{
      we:   1'b0,
      addr: '0,
      data: '0,
      be:   '0
   };

endpackage

// ==== hdl/lp_read_ctrl.sv ====
`timescale 1ns/1ps

module lp_read_ctrl (
   input  logic                  aclk_i,
   input  logic                  rst_n_i,

   input  lp_bus_pkg::lp_rreq_t  rreq_i,
   input  logic                  arvalid_i,
   output logic                  arready_o,

   output mem_if_cfg_pkg::data_t rdata_o,
   output logic                  rvalid_o,
   input  logic                  rready_i,

   output lp_bus_pkg::port_req_t req_o,
   output logic                  req_valid_o,
   input  logic                  grant_i,

   input  mem_if_cfg_pkg::data_t ret_data_i
);

   typedef enum logic [1:0] {
      IDLE,
      REQ,
      WAIT,
      RESP
   } state_e;

   state_e                state_q, state_d;
   mem_if_cfg_pkg::addr_t addr_q;
   mem_if_cfg_pkg::data_t rdata_q;

   // --------------------
   // Control FSM
   // --------------------

   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE: begin
            if (arvalid_i) begin
               state_d = REQ;
            end
         end
         REQ: begin
            if (grant_i) begin
               state_d = WAIT;
            end
         end
         // Bank output is valid during this cycle
         WAIT:    state_d = RESP;
         RESP: begin
            if (rready_i) begin
               state_d = IDLE;
            end
         end
         default: state_d = IDLE;
      endcase
   end

   always_ff @(posedge aclk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   always_ff @(posedge aclk_i) begin
      if (arvalid_i && arready_o) begin
         addr_q <= rreq_i.addr;
      end
      // Hold the word so back-pressure cannot lose it
      if (state_q == WAIT) begin
         rdata_q <= ret_data_i;
      end
   end

   // --------------------
   // Outputs
   // --------------------

   assign arready_o   = (state_q == IDLE);
   assign rvalid_o    = (state_q == RESP);
   assign rdata_o     = rdata_q;
   assign req_valid_o = (state_q == REQ);

   // Only the address changes from one read to the next
   always_comb begin
      req_o      = lp_bus_pkg::PORT_REQ_IDLE;
      req_o.addr = addr_q;
   end

endmodule

// ==== hdl/lp_write_ctrl.sv ====
`timescale 1ns/1ps

module lp_write_ctrl (
   input  logic                  aclk_i,
   input  logic                  rst_n_i,

   input  lp_bus_pkg::lp_wreq_t  wreq_i,
   input  logic                  wvalid_i,
   output logic                  wready_o,

   output logic                  bvalid_o,
   input  logic                  bready_i,

   output lp_bus_pkg::port_req_t req_o,
   output logic                  req_valid_o,
   input  logic                  grant_i
);

   typedef enum logic [1:0] {
      IDLE,
      REQ,
      RESP
   } state_e;

   state_e               state_q, state_d;
   lp_bus_pkg::lp_wreq_t wreq_q;

   // --------------------
   // Control FSM
   // --------------------

   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE: begin
            if (wvalid_i) begin
               state_d = REQ;
            end
         end
         // Keep asking until the bank is ours
         REQ: begin
            if (grant_i) begin
               state_d = RESP;
            end
         end
         RESP: begin
            if (bready_i) begin
               state_d = IDLE;
            end
         end
         default: state_d = IDLE;
      endcase
   end

   always_ff @(posedge aclk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // Request payload, loaded on acceptance only
   always_ff @(posedge aclk_i) begin
      if (wvalid_i && wready_o) begin
         wreq_q <= wreq_i;
      end
   end

   // --------------------
   // Outputs
   // --------------------

   assign wready_o    = (state_q == IDLE);
   assign bvalid_o    = (state_q == RESP);
   assign req_valid_o = (state_q == REQ);

   assign req_o = '{we: 1'b1, addr: wreq_q.addr, data: wreq_q.data, be: wreq_q.be};

   // A pending request must not change under the arbiter
   a_req_stable: assert property (
      @(posedge aclk_i) disable iff (!rst_n_i)
      req_valid_o && !grant_i |=> req_valid_o && $stable(req_o)
   );

endmodule

// ==== hdl/mem_if_cfg_pkg.sv ====
package mem_if_cfg_pkg;

   // --------------------
   // Memory side widths
   // --------------------

   // One bank word
   parameter int DATA_WIDTH = 64;

   // Byte address seen by the requesters
   parameter int ADDR_WIDTH = 32;

   // Byte offset inside a word, dropped before the bank decode
   parameter int OFFSET_BITS = 3;

   // Rows per bank as log2
   parameter int ROW_WIDTH = 13;

   // --------------------
   // Vector types
   // --------------------

   typedef logic [DATA_WIDTH-1:0]   data_t;
   typedef logic [ADDR_WIDTH-1:0]   addr_t;
   typedef logic [DATA_WIDTH/8-1:0] be_t;
   typedef logic [ROW_WIDTH-1:0]    row_t;

   // Access as presented at the SRAM pins, wen low means write
   typedef struct packed {
      logic  wen;
      row_t  row;
      data_t wdata;
      be_t   be;
   } bank_req_t;

endpackage

// ==== hdl/mem_if_multi_bank.sv ====
`timescale 1ns/1ps

module mem_if_multi_bank #(
   parameter int NB_BANKS = 4
) (
   input  logic                                     aclk_i,
   input  logic                                     rst_n_i,

   // --------------------
   // Low-priority bus
   // --------------------
   input  lp_bus_pkg::lp_wreq_t                     lp_wreq_i,
   input  logic                                     lp_wvalid_i,
   output logic                                     lp_wready_o,
   output logic                                     lp_bvalid_o,
   input  logic                                     lp_bready_i,

   input  lp_bus_pkg::lp_rreq_t                     lp_rreq_i,
   input  logic                                     lp_arvalid_i,
   output logic                                     lp_arready_o,
   output mem_if_cfg_pkg::data_t                    lp_rdata_o,
   output logic                                     lp_rvalid_o,
   input  logic                                     lp_rready_i,

   // --------------------
   // High-priority port
   // --------------------
   input  logic                                     hp_cen_i,
   input  logic                                     hp_wen_i,
   input  mem_if_cfg_pkg::addr_t                    hp_addr_i,
   input  mem_if_cfg_pkg::data_t                    hp_wdata_i,
   input  mem_if_cfg_pkg::be_t                      hp_be_i,
   output mem_if_cfg_pkg::data_t                    hp_rdata_o,

   // --------------------
   // SRAM banks
   // --------------------
   output logic [NB_BANKS-1:0]                      bank_cen_o,
   output mem_if_cfg_pkg::bank_req_t [NB_BANKS-1:0] bank_req_o,
   input  mem_if_cfg_pkg::data_t [NB_BANKS-1:0]     bank_q_i
);

   localparam int BANK_BITS = $clog2(NB_BANKS);

   lp_bus_pkg::port_req_t hp_req, lpw_req, lpr_req;
   logic                  lpw_valid, lpr_valid;
   logic                  lpw_grant, lpr_grant;
   logic                  hp_rd, lpr_rd;
   logic [BANK_BITS-1:0]  hp_bank, lpr_bank;
   mem_if_cfg_pkg::data_t lpr_rdata;

   // SRAM-style pins into the common request format
   assign hp_req = '{we: ~hp_wen_i, addr: hp_addr_i, data: hp_wdata_i, be: hp_be_i};

   lp_write_ctrl u_write_ctrl (
      .aclk_i      (aclk_i),
      .rst_n_i     (rst_n_i),
      .wreq_i      (lp_wreq_i),
      .wvalid_i    (lp_wvalid_i),
      .wready_o    (lp_wready_o),
      .bvalid_o    (lp_bvalid_o),
      .bready_i    (lp_bready_i),
      .req_o       (lpw_req),
      .req_valid_o (lpw_valid),
      .grant_i     (lpw_grant)
   );

   lp_read_ctrl u_read_ctrl (
      .aclk_i      (aclk_i),
      .rst_n_i     (rst_n_i),
      .rreq_i      (lp_rreq_i),
      .arvalid_i   (lp_arvalid_i),
      .arready_o   (lp_arready_o),
      .rdata_o     (lp_rdata_o),
      .rvalid_o    (lp_rvalid_o),
      .rready_i    (lp_rready_i),
      .req_o       (lpr_req),
      .req_valid_o (lpr_valid),
      .grant_i     (lpr_grant),
      .ret_data_i  (lpr_rdata)
   );

   bank_xbar #(
      .NB_BANKS (NB_BANKS)
   ) u_xbar (
      .aclk_i      (aclk_i),
      .rst_n_i     (rst_n_i),
      .hp_req_i    (hp_req),
      .hp_valid_i  (~hp_cen_i),
      .lpw_req_i   (lpw_req),
      .lpr_req_i   (lpr_req),
      .lpw_valid_i (lpw_valid),
      .lpr_valid_i (lpr_valid),
      .lpw_grant_o (lpw_grant),
      .lpr_grant_o (lpr_grant),
      .hp_rd_o     (hp_rd),
      .lpr_rd_o    (lpr_rd),
      .hp_bank_o   (hp_bank),
      .lpr_bank_o  (lpr_bank),
      .bank_cen_o  (bank_cen_o),
      .bank_req_o  (bank_req_o)
   );

   read_return #(
      .NB_BANKS (NB_BANKS)
   ) u_read_return (
      .aclk_i      (aclk_i),
      .rst_n_i     (rst_n_i),
      .hp_rd_i     (hp_rd),
      .lpr_rd_i    (lpr_rd),
      .hp_bank_i   (hp_bank),
      .lpr_bank_i  (lpr_bank),
      .bank_q_i    (bank_q_i),
      .hp_rdata_o  (hp_rdata_o),
      .lpr_rdata_o (lpr_rdata)
   );

endmodule

// ==== hdl/read_return.sv ====
`timescale 1ns/1ps

module read_return #(
   parameter int NB_BANKS = 4
) (
   input  logic                                 aclk_i,
   input  logic                                 rst_n_i,

   input  logic                                 hp_rd_i,
   input  logic                                 lpr_rd_i,
   input  logic [$clog2(NB_BANKS)-1:0]          hp_bank_i,
   input  logic [$clog2(NB_BANKS)-1:0]          lpr_bank_i,

   input  mem_if_cfg_pkg::data_t [NB_BANKS-1:0] bank_q_i,

   output mem_if_cfg_pkg::data_t                hp_rdata_o,
   output mem_if_cfg_pkg::data_t                lpr_rdata_o
);

   localparam int BANK_BITS = $clog2(NB_BANKS);

   logic [BANK_BITS-1:0] hp_bank_q;
   logic [BANK_BITS-1:0] lpr_bank_q;

   // Bank that served the last read of each reader
   always_ff @(posedge aclk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         hp_bank_q  <= '0;
         lpr_bank_q <= '0;
      end else begin
         if (hp_rd_i) begin
            hp_bank_q <= hp_bank_i;
         end
         if (lpr_rd_i) begin
            lpr_bank_q <= lpr_bank_i;
         end
      end
   end

   // Q is valid the cycle after the access
   assign hp_rdata_o  = bank_q_i[hp_bank_q];
   assign lpr_rdata_o = bank_q_i[lpr_bank_q];

endmodule

// ==== mem_if_multi_bank.f ====
hdl/mem_if_cfg_pkg.sv
hdl/lp_bus_pkg.sv
hdl/lp_write_ctrl.sv
hdl/lp_read_ctrl.sv
hdl/bank_xbar.sv
hdl/read_return.sv
hdl/mem_if_multi_bank.sv
testbench/mem_if_checker.sv
testbench/tb_mem_if_multi_bank.sv

// ==== testbench/mem_if_checker.sv ====
`timescale 1ns/1ps

module mem_if_checker #(
   parameter int NB_BANKS = 4
) (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  lp_bus_pkg::lp_wreq_t  lp_wreq_i,
   input  logic                  lp_wvalid_i,
   input  logic                  lp_wready_i,
   input  logic                  lp_bvalid_i,
   input  logic                  lp_bready_i,
   input  lp_bus_pkg::lp_rreq_t  lp_rreq_i,
   input  logic                  lp_arvalid_i,
   input  logic                  lp_arready_i,
   input  mem_if_cfg_pkg::data_t lp_rdata_i,
   input  logic                  lp_rvalid_i,
   input  logic                  lp_rready_i,
   input  logic                  hp_cen_i,
   input  logic                  hp_wen_i,
   input  mem_if_cfg_pkg::addr_t hp_addr_i,
   input  mem_if_cfg_pkg::data_t hp_wdata_i,
   input  mem_if_cfg_pkg::be_t   hp_be_i,
   input  mem_if_cfg_pkg::data_t hp_rdata_i,
   input  logic [NB_BANKS-1:0]   bank_cen_i,
   output int                    value_errs_o,
   output int                    protocol_errs_o
);

   // Words reachable before the address wraps
   localparam int DEPTH = NB_BANKS << mem_if_cfg_pkg::ROW_WIDTH;

   mem_if_cfg_pkg::data_t model [DEPTH];
   string                 test_name = "reset";

   logic                  reset_seen = 1'b0;
   logic                  w_out, r_out, b_hold, r_hold, hp_rd_pend;
   lp_bus_pkg::lp_wreq_t  w_pend;
   mem_if_cfg_pkg::data_t hp_exp, r_exp, r_held;

   function automatic int word_index(input mem_if_cfg_pkg::addr_t addr);
      return int'((addr >> mem_if_cfg_pkg::OFFSET_BITS) % DEPTH);
   endfunction

   // Same preload as the bank models, keyed by the word address
   function automatic mem_if_cfg_pkg::data_t fill_word(input int w);
      logic [31:0] a;
      a = w;
      return {a ^ 32'h5a00_0000, ~a};
   endfunction

   task automatic merge(input mem_if_cfg_pkg::addr_t addr, input mem_if_cfg_pkg::data_t data,
                        input mem_if_cfg_pkg::be_t be);
      int w;
      w = word_index(addr);
      for (int i = 0; i < 8; i++) begin
         if (be[i]) begin
            model[w][i*8 +: 8] = data[i*8 +: 8];
         end
      end
   endtask

   task automatic value_err(input string what, input mem_if_cfg_pkg::data_t exp,
                            input mem_if_cfg_pkg::data_t act);
      $display("ERR %s %s: expected %h actual %h", test_name, what, exp, act);
      value_errs_o++;
   endtask

   task automatic protocol_err(input string msg);
      $display("Protocol failure in %s: %s", test_name, msg);
      protocol_errs_o++;
   endtask

   task automatic check_reset_state();
      if (bank_cen_i !== {NB_BANKS{1'b1}}) value_err("bank_cen", {NB_BANKS{1'b1}}, bank_cen_i);
      if (lp_bvalid_i !== 1'b0) value_err("bvalid", 0, lp_bvalid_i);
      if (lp_rvalid_i !== 1'b0) value_err("rvalid", 0, lp_rvalid_i);
      if (lp_wready_i !== 1'b1) value_err("wready", 1, lp_wready_i);
      if (lp_arready_i !== 1'b1) value_err("arready", 1, lp_arready_i);
   endtask

   initial begin
      value_errs_o    = 0;
      protocol_errs_o = 0;
      for (int w = 0; w < DEPTH; w++) begin
         model[w] = fill_word(w);
      end
   end

   always @(posedge clk_i) begin
      if (!rst_n_i) begin
         w_out      = 1'b0;
         r_out      = 1'b0;
         b_hold     = 1'b0;
         r_hold     = 1'b0;
         hp_rd_pend = 1'b0;
      end else begin
         if (!reset_seen) begin
            reset_seen = 1'b1;
            check_reset_state();
         end

         // --------------------
         // High-priority port
         // --------------------
         // Data of a read is due in the following cycle
         if (hp_rd_pend && hp_rdata_i !== hp_exp) begin
            value_err("hp read", hp_exp, hp_rdata_i);
         end
         hp_rd_pend = !hp_cen_i && hp_wen_i;
         if (hp_rd_pend) begin
            hp_exp = model[word_index(hp_addr_i)];
         end else if (!hp_cen_i) begin
            merge(hp_addr_i, hp_wdata_i, hp_be_i);
         end

         // --------------------
         // Low-priority write
         // --------------------
         if (lp_wvalid_i && lp_wready_i && w_out) begin
            protocol_err("write request accepted while the previous write was open");
         end
         if (b_hold && !lp_bvalid_i) begin
            protocol_err("write response withdrawn before it was taken");
         end
         if (lp_bvalid_i && lp_bready_i) begin
            if (w_out) begin
               merge(w_pend.addr, w_pend.data, w_pend.be);
            end else begin
               protocol_err("write response with no write outstanding");
            end
            w_out = 1'b0;
         end
         if (lp_wvalid_i && lp_wready_i) begin
            w_pend = lp_wreq_i;
            w_out  = 1'b1;
         end
         b_hold = lp_bvalid_i && !lp_bready_i;

         // --------------------
         // Low-priority read
         // --------------------
         if (lp_arvalid_i && lp_arready_i && r_out) begin
            protocol_err("read request accepted while the previous read was open");
         end
         if (r_hold && !lp_rvalid_i) begin
            protocol_err("read response withdrawn before it was taken");
         end else if (r_hold && lp_rdata_i !== r_held) begin
            value_err("held read data", r_held, lp_rdata_i);
         end
         if (lp_rvalid_i && lp_rready_i) begin
            if (!r_out) begin
               protocol_err("read response with no read outstanding");
            end else if (lp_rdata_i !== r_exp) begin
               value_err("lp read", r_exp, lp_rdata_i);
            end
            r_out = 1'b0;
         end
         if (lp_arvalid_i && lp_arready_i) begin
            r_exp = model[word_index(lp_rreq_i.addr)];
            r_out = 1'b1;
         end
         r_hold = lp_rvalid_i && !lp_rready_i;
         r_held = lp_rdata_i;
      end
   end

endmodule

// ==== testbench/tb_mem_if_multi_bank.sv ====
`timescale 1ns/1ps

module tb_mem_if_multi_bank;

   localparam int NB_BANKS  = 4;
   localparam int BANK_BITS = $clog2(NB_BANKS);
   localparam int ROWS      = 1 << mem_if_cfg_pkg::ROW_WIDTH;
   localparam int HALF_ROW  = mem_if_cfg_pkg::ROW_WIDTH - 1;
   localparam int WRAP_LSB  = mem_if_cfg_pkg::OFFSET_BITS + BANK_BITS + mem_if_cfg_pkg::ROW_WIDTH;
   localparam int WRAP_BITS = mem_if_cfg_pkg::ADDR_WIDTH - WRAP_LSB;

   localparam int N_HP     = 24;
   localparam int N_LP     = 12;
   localparam int N_CONT   = 4;
   localparam int HP_BURST = 8;
   localparam int N_BP     = 4;
   localparam int N_WRAP   = 3;
   localparam int NUM_OPS  = 2*N_HP + 2*N_LP + N_CONT*(HP_BURST+2) + N_BP*4 + 2*N_WRAP;

   logic                                     clk, rst_n;
   lp_bus_pkg::lp_wreq_t                     lp_wreq;
   lp_bus_pkg::lp_rreq_t                     lp_rreq;
   logic                                     lp_wvalid, lp_wready, lp_bvalid, lp_bready;
   logic                                     lp_arvalid, lp_arready, lp_rvalid, lp_rready;
   mem_if_cfg_pkg::data_t                    lp_rdata, hp_wdata, hp_rdata;
   logic                                     hp_cen, hp_wen;
   mem_if_cfg_pkg::addr_t                    hp_addr;
   mem_if_cfg_pkg::be_t                      hp_be;
   logic [NB_BANKS-1:0]                      bank_cen;
   mem_if_cfg_pkg::bank_req_t [NB_BANKS-1:0] bank_req;
   mem_if_cfg_pkg::data_t [NB_BANKS-1:0]     bank_q;
   int                                       value_errs, protocol_errs;

   logic [31:0]           lfsr = 32'h72c8e6c8;
   mem_if_cfg_pkg::addr_t hp_pool [N_HP];
   mem_if_cfg_pkg::addr_t lp_pool [N_LP];

   // Galois LFSR, one step per random bit
   function automatic mem_if_cfg_pkg::data_t rand_bits(input int n);
      mem_if_cfg_pkg::data_t v;
      logic                  out;
      v = '0;
      for (int i = 0; i < n; i++) begin
         out  = lfsr[0];
         lfsr = (lfsr >> 1) ^ (out ? 32'hd000_0001 : 32'h0);
         v    = {v[62:0], out};
      end
      return v;
   endfunction

   // Top row bit picks the half, low priority below and high priority above
   function automatic mem_if_cfg_pkg::addr_t make_addr(input logic hi_half,
                                                       input logic [BANK_BITS-1:0] bank);
      logic [HALF_ROW-1:0] row;
      row = HALF_ROW'(rand_bits(HALF_ROW));
      return mem_if_cfg_pkg::addr_t'({hi_half, row, bank, {mem_if_cfg_pkg::OFFSET_BITS{1'b0}}});
   endfunction

   function automatic mem_if_cfg_pkg::data_t fill_word(input int w);
      logic [31:0] a;
      a = w;
      return {a ^ 32'h5a00_0000, ~a};
   endfunction

   // --------------------
   // Clock, DUT, banks
   // --------------------

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   mem_if_multi_bank #(.NB_BANKS(NB_BANKS)) dut (
      .aclk_i(clk), .rst_n_i(rst_n),
      .lp_wreq_i(lp_wreq), .lp_wvalid_i(lp_wvalid), .lp_wready_o(lp_wready),
      .lp_bvalid_o(lp_bvalid), .lp_bready_i(lp_bready),
      .lp_rreq_i(lp_rreq), .lp_arvalid_i(lp_arvalid), .lp_arready_o(lp_arready),
      .lp_rdata_o(lp_rdata), .lp_rvalid_o(lp_rvalid), .lp_rready_i(lp_rready),
      .hp_cen_i(hp_cen), .hp_wen_i(hp_wen), .hp_addr_i(hp_addr), .hp_wdata_i(hp_wdata),
      .hp_be_i(hp_be), .hp_rdata_o(hp_rdata),
      .bank_cen_o(bank_cen), .bank_req_o(bank_req), .bank_q_i(bank_q)
   );

   mem_if_checker #(.NB_BANKS(NB_BANKS)) u_checker (
      .clk_i(clk), .rst_n_i(rst_n),
      .lp_wreq_i(lp_wreq), .lp_wvalid_i(lp_wvalid), .lp_wready_i(lp_wready),
      .lp_bvalid_i(lp_bvalid), .lp_bready_i(lp_bready),
      .lp_rreq_i(lp_rreq), .lp_arvalid_i(lp_arvalid), .lp_arready_i(lp_arready),
      .lp_rdata_i(lp_rdata), .lp_rvalid_i(lp_rvalid), .lp_rready_i(lp_rready),
      .hp_cen_i(hp_cen), .hp_wen_i(hp_wen), .hp_addr_i(hp_addr), .hp_wdata_i(hp_wdata),
      .hp_be_i(hp_be), .hp_rdata_i(hp_rdata), .bank_cen_i(bank_cen),
      .value_errs_o(value_errs), .protocol_errs_o(protocol_errs)
   );

   for (genvar b = 0; b < NB_BANKS; b++) begin : g_sram
      mem_if_cfg_pkg::data_t mem [ROWS];
      mem_if_cfg_pkg::data_t q_q = '0;

      initial begin
         for (int r = 0; r < ROWS; r++) begin
            mem[r] = fill_word(r * NB_BANKS + b);
         end
      end

      // Q follows a read one cycle later and holds through writes
      always @(posedge clk) begin
         if (!bank_cen[b] && bank_req[b].wen) begin
            q_q <= mem[bank_req[b].row];
         end else if (!bank_cen[b]) begin
            for (int i = 0; i < 8; i++) begin
               if (bank_req[b].be[i]) begin
                  mem[bank_req[b].row][i*8 +: 8] <= bank_req[b].wdata[i*8 +: 8];
               end
            end
         end
      end

      assign bank_q[b] = q_q;
   end

   // --------------------
   // Driver tasks
   // --------------------

   task automatic hp_op(input logic write, input mem_if_cfg_pkg::addr_t addr);
      hp_cen   = 1'b0;
      hp_wen   = ~write;
      hp_addr  = addr;
      hp_wdata = rand_bits(64);
      hp_be    = mem_if_cfg_pkg::be_t'(rand_bits(8));
      @(negedge clk);
   endtask

   task automatic write_issue(input mem_if_cfg_pkg::addr_t addr, input mem_if_cfg_pkg::data_t data,
                              input mem_if_cfg_pkg::be_t be);
      lp_wreq   = '{addr: addr, data: data, be: be};
      lp_wvalid = 1'b1;
      @(posedge clk);
      while (!lp_wready) begin
         @(posedge clk);
      end
      @(negedge clk);
      lp_wvalid = 1'b0;
   endtask

   task automatic read_issue(input mem_if_cfg_pkg::addr_t addr);
      lp_rreq    = '{addr: addr};
      lp_arvalid = 1'b1;
      @(posedge clk);
      while (!lp_arready) begin
         @(posedge clk);
      end
      @(negedge clk);
      lp_arvalid = 1'b0;
   endtask

   // Ready stays low for stall cycles once the response shows up
   task automatic wait_bresp(input int stall);
      lp_bready = (stall == 0);
      @(posedge clk);
      while (!lp_bvalid) begin
         @(posedge clk);
      end
      if (stall > 0) begin
         repeat (stall) @(negedge clk);
         lp_bready = 1'b1;
         @(posedge clk);
      end
      @(negedge clk);
   endtask

   task automatic wait_rresp(input int stall);
      lp_rready = (stall == 0);
      @(posedge clk);
      while (!lp_rvalid) begin
         @(posedge clk);
      end
      if (stall > 0) begin
         repeat (stall) @(negedge clk);
         lp_rready = 1'b1;
         @(posedge clk);
      end
      @(negedge clk);
   endtask

   task automatic lp_write(input mem_if_cfg_pkg::addr_t addr, input mem_if_cfg_pkg::data_t data,
                           input mem_if_cfg_pkg::be_t be);
      write_issue(addr, data, be);
      wait_bresp(0);
   endtask

   task automatic lp_read(input mem_if_cfg_pkg::addr_t addr);
      read_issue(addr);
      wait_rresp(0);
   endtask

   // --------------------
   // Test sequence
   // --------------------

   initial begin : stimulus
      mem_if_cfg_pkg::addr_t a0, a1, ha;
      mem_if_cfg_pkg::data_t d0, d1;
      mem_if_cfg_pkg::be_t   be;
      int                    stall;

      rst_n      = 1'b0;
      lp_wreq    = '0;
      lp_wvalid  = 1'b0;
      lp_bready  = 1'b1;
      lp_rreq    = '0;
      lp_arvalid = 1'b0;
      lp_rready  = 1'b1;
      hp_cen     = 1'b1;
      hp_wen     = 1'b1;
      hp_addr    = '0;
      hp_wdata   = '0;
      hp_be      = '0;
      repeat (10) @(negedge clk);
      rst_n = 1'b1;
      repeat (3) @(negedge clk);

      u_checker.test_name = "hp_access";
      for (int i = 0; i < N_HP; i++) begin
         hp_pool[i] = make_addr(1'b1, BANK_BITS'(rand_bits(BANK_BITS)));
         hp_op(1'b1, hp_pool[i]);
      end
      for (int i = 0; i < N_HP; i++) begin
         hp_op(1'b0, hp_pool[i]);
      end
      hp_cen = 1'b1;

      u_checker.test_name = "lp_access";
      for (int i = 0; i < N_LP; i++) begin
         lp_pool[i] = make_addr(1'b0, BANK_BITS'(rand_bits(BANK_BITS)));
         d0 = rand_bits(64);
         lp_write(lp_pool[i], d0, mem_if_cfg_pkg::be_t'(rand_bits(8)));
      end
      for (int i = N_LP - 1; i >= 0; i--) begin
         lp_read(lp_pool[i]);
      end

      // Both low-priority requests wait on a bank that high priority keeps busy
      u_checker.test_name = "contention";
      for (int k = 0; k < N_CONT; k++) begin
         a0 = make_addr(1'b0, BANK_BITS'(k));
         a1 = a0 ^ (mem_if_cfg_pkg::addr_t'(1) << (mem_if_cfg_pkg::OFFSET_BITS + BANK_BITS));
         d0 = rand_bits(64);
         fork
            lp_write(a0, d0, '1);
            lp_read(a1);
            begin
               for (int j = 0; j < HP_BURST / 2; j++) begin
                  ha = make_addr(1'b1, BANK_BITS'(k));
                  hp_op(1'b1, ha);
                  hp_op(1'b0, ha);
               end
               hp_cen = 1'b1;
            end
         join
      end

      u_checker.test_name = "back_pressure";
      for (int k = 0; k < N_BP; k++) begin
         a0    = make_addr(1'b0, BANK_BITS'(rand_bits(BANK_BITS)));
         a1    = make_addr(1'b0, BANK_BITS'(rand_bits(BANK_BITS)));
         d0    = rand_bits(64);
         d1    = rand_bits(64);
         be    = mem_if_cfg_pkg::be_t'(rand_bits(8));
         stall = 1 + int'(rand_bits(4));
         write_issue(a0, d0, '1);
         // Next request waits while the held response is pending
         fork
            wait_bresp(stall);
            write_issue(a1, d1, be);
         join
         wait_bresp(0);
         stall = 1 + int'(rand_bits(4));
         read_issue(a0);
         fork
            wait_rresp(stall);
            read_issue(a1);
         join
         wait_rresp(0);
      end

      u_checker.test_name = "addr_wrap";
      for (int k = 0; k < N_WRAP; k++) begin
         a0 = make_addr(1'b0, BANK_BITS'(rand_bits(BANK_BITS)));
         a1 = a0 | (mem_if_cfg_pkg::addr_t'(rand_bits(WRAP_BITS)) << WRAP_LSB)
                 | (mem_if_cfg_pkg::addr_t'(1) << WRAP_LSB);
         d0 = rand_bits(64);
         lp_write(a1, d0, '1);
         lp_read(a0);
      end

      repeat (4) @(negedge clk);
      $display("Error count: %0d value errors, %0d protocol errors", value_errs, protocol_errs);
      if (value_errs == 0 && protocol_errs == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

   // Generous budget of 40 cycles per operation
   initial begin
      #(NUM_OPS * 40 * 4);
      $display("Timeout: the tests did not finish within %0d ns", NUM_OPS * 40 * 4);
      $display("Errors found");
      $finish;
   end

endmodule
